// ==== hdl/tv_pkg.sv ====
package tv_pkg;

   //////////////////////////////////////////////////
   // Bus address map
   //////////////////////////////////////////////////

   localparam logic [21:0] fb_base  = 22'o17000000;  // Frame buffer, matched on bits 21..15
   localparam logic [21:0] reg_base = 22'o17377760;  // Eight control registers, bits 21..3
   localparam int          fb_addr_w = 15;           // Word offset inside the frame buffer

   //////////////////////////////////////////////////
   // Video timing, 1280 x 1024 at 60 Hz
   //////////////////////////////////////////////////

   localparam int h_visible = 1280;                  // Clocks per line
   localparam int h_front   = 48;
   localparam int h_sync    = 112;
   localparam int h_back    = 248;
   localparam int h_total   = h_visible + h_front + h_sync + h_back;  // 1688

   localparam int v_visible = 1024;                  // Lines per frame
   localparam int v_front   = 1;
   localparam int v_sync    = 3;
   localparam int v_back    = 38;
   localparam int v_total   = v_visible + v_front + v_sync + v_back;  // 1066

   // Centered 768 x 896 window
   localparam int words_per_line = 24;
   localparam int win_left   = 256;
   localparam int win_width  = words_per_line * 32;   // 768
   localparam int win_top    = 64;
   localparam int win_height = 896;
   localparam int fb_words   = words_per_line * win_height;  // 21504

   //////////////////////////////////////////////////
   // Shared structs
   //////////////////////////////////////////////////

   typedef struct packed {
      logic [21:0] addr;
      logic [31:0] wdata;
      logic        write;                            // 1 = write, 0 = read
      logic        req;
   } bus_req_t;

   typedef struct packed {
      logic                 en;                      // Access this cycle
      logic                 we;
      logic [fb_addr_w-1:0] addr;
      logic [31:0]          wdata;
   } fb_port_t;

   typedef struct packed {
      logic [10:0] hcount;
      logic [10:0] vcount;
      logic        hsync;                            // Active high
      logic        vsync;                            // Active high
      logic        blank;                            // Outside 1280 x 1024
      logic        in_win;                           // Inside the frame buffer window
      logic        line_start;                       // hcount == 0
      logic        vblank_start;                     // First cycle of line 1024
   } video_timing_t;

   typedef struct packed {
      logic pixel;
      logic hsync;
      logic vsync;
      logic blank;
   } video_out_t;

   // Register offset 0, int_enable is bit 0
   typedef struct packed {
      logic [29:0] spare;                            // Read back as written
      logic        invert;                           // Swap black and white
      logic        int_enable;                       // Vertical blank interrupt
   } tv_ctrl_t;

endpackage

// ==== hdl/tv_bus_slave.sv ====
`timescale 1ns/1ps

module tv_bus_slave
   import tv_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   input  bus_req_t      bus,
   input  logic [31:0]   fb_rdata,
   input  video_timing_t timing,
   output logic          decode,
   output logic          ack,
   output logic [31:0]   dataout,
   output fb_port_t      fb,
   output tv_ctrl_t      ctrl,
   output logic          interrupt
);

   logic        in_fb;                               // Address hits the frame buffer
   logic        in_reg;                              // Address hits the register block
   logic [1:0]  busy;                                // Ack pipeline
   logic        reg_wr;
   logic        rd_pend;                             // Read issued last cycle
   logic        rd_fb;                               // ... and it went to the frame buffer
   logic [2:0]  rd_off;                              // ... register offset of that read
   logic [31:0] reg_rdata;

   //////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////

   assign in_fb  = bus.addr[21:15] == fb_base[21:15];
   assign in_reg = bus.addr[21:3] == reg_base[21:3];
   assign decode = bus.req & (in_fb | in_reg);
   assign reg_wr = decode & in_reg & bus.write;

   // Frame buffer port, driven in the decode cycle
   assign fb.en    = decode & in_fb;
   assign fb.we    = bus.write;
   assign fb.addr  = bus.addr[fb_addr_w-1:0];
   assign fb.wdata = bus.wdata;

   assign ack = busy[1];                             // Two cycles after decode

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy    <= 2'b00;
         rd_pend <= 1'b0;
      end
      else
      begin
         busy    <= {busy[0], decode};
         rd_pend <= decode & ~bus.write;
      end
   end

   always_ff @(posedge clk)
   begin
      if (decode & ~bus.write)
      begin
         rd_fb  <= in_fb;
         rd_off <= bus.addr[2:0];
      end
   end

   //////////////////////////////////////////////////
   // Registers and read data
   //////////////////////////////////////////////////

   always_comb
   begin
      case (rd_off)
         3'd0:    reg_rdata = ctrl;
         3'd1:    reg_rdata = {31'b0, interrupt};    // Status, bit 0 pending
         default: reg_rdata = 32'b0;
      endcase
   end

   // RAM word arrives the cycle after decode, hold until the next read
   always_ff @(posedge clk)
   begin
      if (rd_pend)
         dataout <= rd_fb ? fb_rdata : reg_rdata;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ctrl      <= '0;
         interrupt <= 1'b0;
      end
      else
      begin
         if (reg_wr && bus.addr[2:0] == 3'd0)
            ctrl <= bus.wdata;
         if (reg_wr && bus.addr[2:0] == 3'd1)
            interrupt <= 1'b0;                       // Any write to status clears
         if (timing.vblank_start && ctrl.int_enable)
            interrupt <= 1'b1;                       // New vblank wins over a clear
      end
   end

endmodule

// ==== hdl/tv_frame_ram.sv ====
`timescale 1ns/1ps

module tv_frame_ram
   import tv_pkg::*;
(
   input  logic                 clk,
   input  fb_port_t             fb,
   input  logic [fb_addr_w-1:0] scan_addr,
   output logic [31:0]          fb_rdata,
   output logic [31:0]          scan_rdata
);

   logic [31:0] mem [0:fb_words-1];
   logic        fb_ok;                               // Bus offset inside the 21504 words
   logic        scan_ok;

   initial
   begin
      for (int i = 0; i < fb_words; i++)
         mem[i] = 32'b0;                             // Unwritten words read as 0
   end

   assign fb_ok   = fb.addr < fb_addr_w'(fb_words);
   assign scan_ok = scan_addr < fb_addr_w'(fb_words);

   // Bus port, read before write
   always_ff @(posedge clk)
   begin
      if (fb.en)
      begin
         if (fb.we && fb_ok)
            mem[fb.addr] <= fb.wdata;
         fb_rdata <= fb_ok ? mem[fb.addr] : 32'b0;   // Offsets past the end read 0
      end
   end

   always_ff @(posedge clk)
      scan_rdata <= scan_ok ? mem[scan_addr] : 32'b0;  // Scan port, read every clock

endmodule

// ==== hdl/tv_video_timer.sv ====
`timescale 1ns/1ps

module tv_video_timer
   import tv_pkg::*;
(
   input  logic          clk,
   input  logic          reset,
   output video_timing_t timing
);

   logic [10:0] hcount;
   logic [10:0] vcount;
   logic        h_wrap;                              // Last clock of the line
   logic        h_vis;
   logic        v_vis;
   logic        h_win;
   logic        v_win;

   //////////////////////////////////////////////////
   // Counters
   //////////////////////////////////////////////////

   assign h_wrap = hcount == 11'(h_total - 1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         hcount <= 11'd0;
         vcount <= 11'd0;
      end
      else if (h_wrap)
      begin
         hcount <= 11'd0;
         if (vcount == 11'(v_total - 1))
            vcount <= 11'd0;                         // Frame wrap
         else
            vcount <= vcount + 11'd1;
      end
      else
         hcount <= hcount + 11'd1;
   end

   //////////////////////////////////////////////////
   // Flags
   //////////////////////////////////////////////////

   assign h_vis = hcount < 11'(h_visible);
   assign v_vis = vcount < 11'(v_visible);
   assign h_win = hcount >= 11'(win_left) && hcount < 11'(win_left + win_width);
   assign v_win = vcount >= 11'(win_top) && vcount < 11'(win_top + win_height);

   always_comb
   begin
      timing.hcount = hcount;
      timing.vcount = vcount;
      // Sync pulses follow the front porch
      timing.hsync  = hcount >= 11'(h_visible + h_front)
                      && hcount < 11'(h_visible + h_front + h_sync);
      timing.vsync  = vcount >= 11'(v_visible + v_front)
                      && vcount < 11'(v_visible + v_front + v_sync);
      timing.blank  = ~(h_vis & v_vis);
      timing.in_win = h_win & v_win;
      timing.line_start   = hcount == 11'd0;
      timing.vblank_start = hcount == 11'd0 && vcount == 11'(v_visible);
   end

endmodule

// ==== hdl/tv_scan_fsm.sv ====
`timescale 1ns/1ps

module tv_scan_fsm
   import tv_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  video_timing_t        timing,
   input  tv_ctrl_t             ctrl,
   input  logic [31:0]          scan_rdata,
   output logic [fb_addr_w-1:0] scan_addr,
   output video_out_t           video
);

   typedef enum logic [1:0] {s_idle, s_prefetch, s_shift} state_t;

   state_t               state;                      // Shift trails the window flag by one clock
   logic [4:0]           pix_cnt;                    // Pixel within the current word
   logic                 fetch;                      // First pixel of a 32-pixel group
   logic [fb_addr_w-1:0] word_addr;                  // Next frame word to fetch
   logic [31:0]          shreg;                      // Current word shifted out LSB first
   logic                 first_d1;                   // Word on scan_rdata this cycle
   logic                 hsync_d1;
   logic                 vsync_d1;
   logic                 blank_d1;
   logic                 bit_now;

   //////////////////////////////////////////////////
   // Line state and fetch
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset || timing.vblank_start)
         state <= s_idle;
      else
      begin
         case (state)
            s_idle:                                  // Wait for the top window line
               if (timing.line_start && timing.vcount == 11'(win_top))
                  state <= s_prefetch;
            s_prefetch:                              // Left margin of a window line
               if (timing.in_win)
                  state <= s_shift;
               else if (timing.line_start && timing.vcount == 11'(win_top + win_height))
                  state <= s_idle;
            s_shift:
               if (!timing.in_win)
                  state <= s_prefetch;
            default:
               state <= s_idle;
         endcase
      end
   end

   assign fetch     = state != s_idle && timing.in_win && pix_cnt == 5'd0;
   assign scan_addr = word_addr;                     // Word lands on scan_rdata next cycle

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pix_cnt   <= 5'd0;
         word_addr <= '0;
      end
      else
      begin
         pix_cnt <= timing.in_win ? pix_cnt + 5'd1 : 5'd0;  // Wraps every 32
         if (timing.vblank_start)
            word_addr <= '0;                         // Frame restart
         else if (fetch)
            word_addr <= word_addr + 1'b1;           // Lines are contiguous
      end
   end

   //////////////////////////////////////////////////
   // Two-stage output pipeline
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         first_d1 <= 1'b0;
         hsync_d1 <= 1'b0;
         vsync_d1 <= 1'b0;
         blank_d1 <= 1'b1;
      end
      else
      begin
         first_d1 <= fetch;
         hsync_d1 <= timing.hsync;
         vsync_d1 <= timing.vsync;
         blank_d1 <= timing.blank;
      end
   end

   assign bit_now = first_d1 ? scan_rdata[0] : shreg[0];

   // Load on the group's first pixel, otherwise shift right
   always_ff @(posedge clk)
      shreg <= first_d1 ? {1'b0, scan_rdata[31:1]} : {1'b0, shreg[31:1]};

   always_ff @(posedge clk)
   begin
      if (reset)
         video <= '{pixel: 1'b0, hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
      else
      begin
         video.pixel <= (state == s_shift) & (bit_now ^ ctrl.invert);  // Margins stay black
         video.hsync <= hsync_d1;
         video.vsync <= vsync_d1;
         video.blank <= blank_d1;
      end
   end

endmodule

// ==== hdl/tv_display.sv ====
`timescale 1ns/1ps

module tv_display
   import tv_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [31:0] datain,
   input  logic        req,
   input  logic        write,
   output logic [31:0] dataout,
   output logic        ack,
   output logic        decode,
   output logic        interrupt,
   output logic        pixel,
   output logic        hsync,
   output logic        vsync,
   output logic        blank
);

   bus_req_t             bus;
   fb_port_t             fb;
   logic [31:0]          fb_rdata;
   logic [31:0]          scan_rdata;
   logic [fb_addr_w-1:0] scan_addr;
   video_timing_t        timing;
   tv_ctrl_t             ctrl;
   video_out_t           video;

   assign bus = '{addr: addr, wdata: datain, write: write, req: req};

   tv_bus_slave u_slave (
      .clk       (clk),
      .reset     (reset),
      .bus       (bus),
      .fb_rdata  (fb_rdata),
      .timing    (timing),
      .decode    (decode),
      .ack       (ack),
      .dataout   (dataout),
      .fb        (fb),
      .ctrl      (ctrl),
      .interrupt (interrupt)
   );

   tv_frame_ram u_ram (
      .clk        (clk),
      .fb         (fb),
      .scan_addr  (scan_addr),
      .fb_rdata   (fb_rdata),
      .scan_rdata (scan_rdata)
   );

   tv_video_timer u_timer (
      .clk    (clk),
      .reset  (reset),
      .timing (timing)
   );

   tv_scan_fsm u_scan (
      .clk        (clk),
      .reset      (reset),
      .timing     (timing),
      .ctrl       (ctrl),
      .scan_rdata (scan_rdata),
      .scan_addr  (scan_addr),
      .video      (video)
   );

   // Video out to the pins
   assign pixel = video.pixel;
   assign hsync = video.hsync;
   assign vsync = video.vsync;
   assign blank = video.blank;

endmodule

// ==== test/tv_clock_gen.sv ====
`timescale 1ns/1ps

module tv_clock_gen
(
   output logic clk,
   output logic reset
);

   // 4 ns pixel clock
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial
   begin
      reset = 1'b1;                                  // Held for three rising edges
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;                                  // Released on a falling edge
   end

endmodule

// ==== test/tv_display_tb.sv ====
`timescale 1ns/1ps

module tv_display_tb
   import tv_pkg::*;
();

   localparam int max_cycles = 3 * v_total * h_total + 2000;  // Three frames and slack
   localparam video_out_t video_idle = '{pixel: 1'b0, hsync: 1'b0, vsync: 1'b0, blank: 1'b1};

   logic        clk;
   logic        reset;
   logic [21:0] addr;
   logic [31:0] datain;
   logic        req;
   logic        write;
   logic [31:0] dataout;
   logic        ack;
   logic        decode;
   logic        interrupt;
   logic        pixel;
   logic        hsync;
   logic        vsync;
   logic        blank;

   logic [31:0] shadow [0:fb_words-1];               // Frame buffer model
   logic [31:0] rng;
   string       test_name;
   int          cycles = 0;
   int          hc;                                  // Model counters reset like the timer
   int          vc;
   int          frame_cnt;
   tv_ctrl_t    ctrl_sh;                             // Control register model
   logic        exp_irq;
   logic        exp_dec;
   logic        dec_d1;
   logic        dec_d2;                              // Expected ack
   logic        rd_check;                            // A read is outstanding
   logic [31:0] rd_exp;
   video_out_t  e1;                                  // Expected video over two stages
   video_out_t  e2;

   tv_clock_gen u_clk (.clk(clk), .reset(reset));

   tv_display u_dut (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .datain    (datain),
      .req       (req),
      .write     (write),
      .dataout   (dataout),
      .ack       (ack),
      .decode    (decode),
      .interrupt (interrupt),
      .pixel     (pixel),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank)
   );

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Frame buffer spans 32K words from its base
   function automatic logic in_fb_area(input logic [21:0] a);
      return a >= fb_base && a < fb_base + 22'o100000;
   endfunction

   function automatic logic in_reg_area(input logic [21:0] a);
      return a >= reg_base && a < reg_base + 22'd8;  // Eight registers
   endfunction

   function automatic video_out_t expect_video(input int h, input int v, input logic inv);
      video_out_t  o;
      int          x;
      int          y;
      logic [31:0] w;
      o.hsync = h >= h_visible + h_front && h < h_visible + h_front + h_sync;
      o.vsync = v >= v_visible + v_front && v < v_visible + v_front + v_sync;
      o.blank = !(h < h_visible && v < v_visible);
      o.pixel = 1'b0;                                // Margins black
      if (h >= win_left && h < win_left + win_width && v >= win_top && v < win_top + win_height)
      begin
         x = h - win_left;
         y = v - win_top;
         w = shadow[y * words_per_line + x / 32];
         o.pixel = w[x % 32] ^ inv;                  // LSB first
      end
      return o;
   endfunction

   assign exp_dec = req && (in_fb_area(addr) || in_reg_area(addr));

   always @(posedge clk)
   begin
      if (reset)
      begin
         hc        <= 0;
         vc        <= 0;
         frame_cnt <= 0;
      end
      else if (hc == h_total - 1)
      begin
         hc <= 0;
         if (vc == v_total - 1)
         begin
            vc        <= 0;
            frame_cnt <= frame_cnt + 1;
         end
         else
            vc <= vc + 1;
      end
      else
         hc <= hc + 1;
   end

   always @(posedge clk)
   begin
      if (reset)
      begin
         ctrl_sh <= '0;
         exp_irq <= 1'b0;
         dec_d1  <= 1'b0;
         dec_d2  <= 1'b0;
         e1      <= video_idle;
         e2      <= video_idle;
      end
      else
      begin
         dec_d1 <= exp_dec;
         dec_d2 <= dec_d1;
         if (req && write && in_reg_area(addr) && addr[2:0] == 3'd0)
            ctrl_sh <= datain;
         if (req && write && in_reg_area(addr) && addr[2:0] == 3'd1)
            exp_irq <= 1'b0;                         // Status write clears
         if (hc == 0 && vc == v_visible && ctrl_sh.int_enable)
            exp_irq <= 1'b1;
         e1 <= expect_video(hc, vc, ctrl_sh.invert);
         e2 <= e1;
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      $display("sim failed");
      $fatal(1);
   endtask

   a_decode: assert property (@(posedge clk) disable iff (reset) decode == exp_dec)
      else report_mismatch("decode", 32'(exp_dec), 32'(decode));
   a_ack: assert property (@(negedge clk) disable iff (reset) ack == dec_d2)
      else report_mismatch("ack", 32'(dec_d2), 32'(ack));
   a_rdata: assert property (@(negedge clk) disable iff (reset)
                             !(ack && rd_check) || dataout == rd_exp)
      else report_mismatch("dataout", rd_exp, dataout);
   a_irq: assert property (@(negedge clk) disable iff (reset) interrupt == exp_irq)
      else report_mismatch("interrupt", 32'(exp_irq), 32'(interrupt));
   a_sync: assert property (@(negedge clk) disable iff (reset)
                            {hsync, vsync, blank} == {e2.hsync, e2.vsync, e2.blank})
      else report_mismatch("hsync/vsync/blank", 32'({e2.hsync, e2.vsync, e2.blank}),
                           32'({hsync, vsync, blank}));
   a_pixel: assert property (@(negedge clk) disable iff (reset) pixel == e2.pixel)
      else report_mismatch($sformatf("pixel x=%0d y=%0d", hc, vc), 32'(e2.pixel), 32'(pixel));

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("Timeout: the test did not finish within %0d cycles", max_cycles);
         $display("sim failed");
         $fatal(1);
      end
   end

   //////////////////////////////////////////////////
   // Bus tasks
   //////////////////////////////////////////////////

   task automatic bus_write(input logic [21:0] a, input logic [31:0] d);
      @(negedge clk);
      rd_check = 1'b0;
      addr     = a;
      datain   = d;
      write    = 1'b1;
      req      = 1'b1;
      if (in_fb_area(a) && int'(a - fb_base) < fb_words)
         shadow[int'(a - fb_base)] = d;
      @(negedge clk);
      req   = 1'b0;
      write = 1'b0;
      while (!ack) @(negedge clk);                   // Ack two cycles on
   endtask

   task automatic bus_read(input logic [21:0] a);
      int off;
      @(negedge clk);
      if (in_fb_area(a))
      begin
         off    = int'(a - fb_base);
         rd_exp = off < fb_words ? shadow[off] : 32'b0;
      end
      else if (a[2:0] == 3'd0)
         rd_exp = ctrl_sh;
      else if (a[2:0] == 3'd1)
         rd_exp = {31'b0, exp_irq};                  // Status word
      else
         rd_exp = 32'b0;
      rd_check = 1'b1;
      addr     = a;
      write    = 1'b0;
      req      = 1'b1;
      @(negedge clk);
      req = 1'b0;
      while (!ack) @(negedge clk);
   endtask

   // One request cycle at any address without waiting for ack
   task automatic poke(input logic [21:0] a, input logic r);
      @(negedge clk);
      rd_check = 1'b0;
      addr     = a;
      write    = 1'b0;
      req      = r;
      @(negedge clk);
      req = 1'b0;
      repeat (3) @(negedge clk);
   endtask

   task automatic wait_line(input int f, input int line);
      while (frame_cnt != f || vc != line) @(negedge clk);
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial
   begin
      addr      = '0;
      datain    = '0;
      req       = 1'b0;
      write     = 1'b0;
      rd_check  = 1'b0;
      rd_exp    = '0;
      rng       = 32'h8c45cb13;
      test_name = "reset";
      for (int i = 0; i < fb_words; i++)
         shadow[i] = 32'b0;
      @(negedge clk);
      while (reset) @(negedge clk);
      repeat (8) @(negedge clk);

      test_name = "empty_read";                      // Nothing written yet
      repeat (16)
      begin
         rng = xorshift(rng);
         bus_read(fb_base + 22'(rng % 32'(fb_words)));
      end

      test_name = "decode";
      repeat (48)
      begin
         rng = xorshift(rng);
         poke(rng[21:0], 1'b1);
      end
      poke(fb_base - 22'd1, 1'b1);                   // Just outside each area
      poke(fb_base + 22'o100000, 1'b1);
      poke(reg_base - 22'd1, 1'b1);
      poke(reg_base + 22'd8, 1'b1);
      poke(fb_base, 1'b0);                           // Without req there is no decode
      poke(reg_base, 1'b0);

      test_name = "registers";
      rng = xorshift(rng);
      bus_write(reg_base, {rng[31:2], 2'b00});       // Spare bits only
      for (int i = 0; i < 8; i++)
         bus_read(reg_base + 22'(i));
      bus_write(reg_base + 22'd5, rng);
      bus_read(reg_base + 22'd5);

      test_name = "fill_readback";
      for (int i = 0; i < fb_words; i++)
      begin
         rng = xorshift(rng);
         bus_write(fb_base + 22'(i), rng);
      end
      repeat (64)
      begin
         rng = xorshift(rng);
         bus_read(fb_base + 22'(rng % 32'(fb_words)));
      end

      // Second frame shows plain pixels and no vblank interrupt yet
      test_name = "frame_pixels";
      wait_line(1, v_visible + 6);

      test_name = "invert_irq";
      rng = xorshift(rng);
      bus_write(reg_base, {rng[31:2], 2'b11});       // Invert and int_enable
      bus_read(reg_base);
      wait_line(2, v_visible + 6);                   // Third frame drawn inverted
      bus_read(reg_base + 22'd1);                    // Pending
      bus_write(reg_base + 22'd1, 32'b0);
      bus_read(reg_base + 22'd1);
      repeat (16) @(negedge clk);

      $display("sim passed");
      $finish;
   end

endmodule

// ==== tv_display.f ====
hdl/tv_pkg.sv
hdl/tv_bus_slave.sv
hdl/tv_frame_ram.sv
hdl/tv_video_timer.sv
hdl/tv_scan_fsm.sv
hdl/tv_display.sv
test/tv_clock_gen.sv
test/tv_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tv_display_tb -f tv_display.f \
   -Mdir obj_dir -o tv_display_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tv_display_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qx "sim passed" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
